// ==== source/hbus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Single HyperRAM, linear memory space only, no byte masks
// ~~~~~~~~~~~~~~~~~~~~
package hbus_pkg;

    // Bus and user widths
    typedef logic [15:0] hbus_word_t;
    typedef logic [7:0]  hbus_byte_t;
    typedef logic [31:0] hbus_addr_t;
    typedef logic [47:0] hbus_ca_t;

    // Counters
    typedef logic [4:0] burst_len_t;
    typedef logic [4:0] credit_t;
    typedef logic [4:0] lat_count_t;
    typedef logic [6:0] timeout_t;

    typedef enum logic [2:0] {
        st_reset,
        st_idle,
        st_command,
        st_latency,
        st_write,
        st_read,
        st_done,
        st_error
    } hbus_state_e;

    // 1x initial latency in clk cycles, doubled when RWDS is high
    localparam int TACC_CLOCKS = 6;

    // Device reset pulse after controller reset
    localparam int RESET_CYCLES = 4;

    // Read cycles allowed without a word
    localparam int READ_TIMEOUT = 64;

    // Write buffer depth and initial user credits
    localparam int WR_CREDITS = 16;

    // Read credits held by the controller after reset
    localparam int RD_CREDITS = 16;

    localparam int FIFO_PTR_W = $clog2(WR_CREDITS);

    // Command/address length in bus words
    localparam int CA_WORDS = 3;

endpackage

// ==== source/hbus_ca_builder.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Linear memory bursts only; addr_i is a word address
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hbus_ca_builder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_i,
    input  logic                   shift_i,
    input  logic                   we_i,
    input  hbus_pkg::hbus_addr_t   addr_i,
    output hbus_pkg::hbus_word_t   ca_word_o
);

    hbus_pkg::hbus_ca_t ca_q;

    // Shifted out from the top, one bus word per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ca_q <= '0;
        end else if (load_i) begin
            ca_q[47]    <= ~we_i;          // 1 for read
            ca_q[46]    <= 1'b0;           // memory space
            ca_q[45]    <= 1'b1;           // linear burst
            ca_q[44:16] <= addr_i[31:3];   // row and upper column
            ca_q[15:3]  <= 13'd0;          // reserved
            ca_q[2:0]   <= addr_i[2:0];    // lower column
        end else if (shift_i) begin
            ca_q <= {ca_q[31:0], 16'h0000};
        end
    end

    assign ca_word_o = ca_q[47:32];

endmodule

// ==== source/hbus_latency_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// RWDS is sampled once, in the last command cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hbus_latency_counter (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    input  logic rwds_sample_i,
    input  logic run_i,
    input  logic to_run_i,
    input  logic word_seen_i,
    output logic lat_done_o,
    output logic to_expired_o
);

    hbus_pkg::lat_count_t lat_q;
    hbus_pkg::timeout_t   to_q;

    // Initial latency, 1x or 2x
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lat_q <= '0;
        end else if (start_i) begin
            if (rwds_sample_i) begin
                lat_q <= hbus_pkg::lat_count_t'(2 * hbus_pkg::TACC_CLOCKS);
            end else begin
                lat_q <= hbus_pkg::lat_count_t'(hbus_pkg::TACC_CLOCKS);
            end
        end else if (run_i && lat_q != '0) begin
            lat_q <= lat_q - 1'b1;
        end
    end

    assign lat_done_o = run_i && (lat_q == hbus_pkg::lat_count_t'(1));

    // Read timeout, restarted by every word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            to_q <= hbus_pkg::timeout_t'(hbus_pkg::READ_TIMEOUT - 1);
        end else if (!to_run_i || word_seen_i) begin
            to_q <= hbus_pkg::timeout_t'(hbus_pkg::READ_TIMEOUT - 1);
        end else if (to_q != '0) begin
            to_q <= to_q - 1'b1;
        end
    end

    assign to_expired_o = to_run_i && (to_q == '0);

endmodule

// ==== source/hbus_ddr_io.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Bytes are edge aligned to hbus_ck; no 90 degree clock
// Idle RWDS must be pulled low on the board
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hbus_ddr_io (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ck_en_i,
    input  logic                   dq_oe_i,
    input  logic                   rwds_oe_i,
    input  hbus_pkg::hbus_word_t   tx_word_i,
    output hbus_pkg::hbus_byte_t   rx_rise_o,
    output hbus_pkg::hbus_byte_t   rx_fall_o,
    output logic                   rwds_rise_o,
    output logic                   rwds_fall_o,
    output logic                   hbus_ck_o,
    inout  hbus_pkg::hbus_byte_t   hbus_dq_io,
    inout  wire                    hbus_rwds_io
);

    logic                 ck_en_q;
    hbus_pkg::hbus_byte_t tx_byte;
    hbus_pkg::hbus_byte_t rx_hi_q;
    logic                 rwds_hi_q;

    // Enable only changes while clk is low, so the gated clock stays clean
    always_ff @(negedge clk or posedge rst) begin
        if (rst) begin
            ck_en_q <= 1'b0;
        end else begin
            ck_en_q <= ck_en_i;
        end
    end

    assign hbus_ck_o = clk & ck_en_q;

    // High byte in the clk-high half, low byte in the clk-low half
    assign tx_byte      = clk ? tx_word_i[15:8] : tx_word_i[7:0];
    assign hbus_dq_io   = dq_oe_i ? tx_byte : 'z;
    assign hbus_rwds_io = rwds_oe_i ? 1'b0 : 1'bz;

    // Capture the high half at its closing edge
    always_ff @(negedge clk) begin
        rx_hi_q <= hbus_dq_io;
    end

    always_ff @(negedge clk or posedge rst) begin
        if (rst) begin
            rwds_hi_q <= 1'b0;
        end else begin
            rwds_hi_q <= hbus_rwds_io;
        end
    end

    // Both halves of a cycle leave together after the next rising edge
    always_ff @(posedge clk) begin
        rx_rise_o <= rx_hi_q;
        rx_fall_o <= hbus_dq_io;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rwds_rise_o <= 1'b0;
            rwds_fall_o <= 1'b0;
        end else begin
            rwds_rise_o <= rwds_hi_q;
            rwds_fall_o <= hbus_rwds_io;
        end
    end

endmodule

// ==== source/hbus_write_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// No full check; the user must respect its write credits
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hbus_write_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_valid_i,
    input  hbus_pkg::hbus_word_t   wr_data_i,
    input  logic                   pop_i,
    output hbus_pkg::hbus_word_t   head_o,
    output hbus_pkg::credit_t      count_o,
    output logic                   wr_credit_o
);

    hbus_pkg::hbus_word_t              mem [hbus_pkg::WR_CREDITS];
    logic [hbus_pkg::FIFO_PTR_W-1:0]   wr_ptr_q;
    logic [hbus_pkg::FIFO_PTR_W-1:0]   rd_ptr_q;
    hbus_pkg::credit_t                 count_q;
    logic                              credit_q;

    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            if (wr_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q  <= count_q + hbus_pkg::credit_t'(wr_valid_i)
                                - hbus_pkg::credit_t'(pop_i);
            // One credit back per word sent to the bus
            credit_q <= pop_i;
        end
    end

    assign head_o      = mem[rd_ptr_q];
    assign count_o     = count_q;
    assign wr_credit_o = credit_q;

endmodule

// ==== source/hbus_read_capture.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Words are qualified by RWDS high then low within one clk cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hbus_read_capture (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable_i,
    input  hbus_pkg::hbus_byte_t   rx_rise_i,
    input  hbus_pkg::hbus_byte_t   rx_fall_i,
    input  logic                   rwds_rise_i,
    input  logic                   rwds_fall_i,
    input  logic                   rd_credit_i,
    output logic                   rd_valid_o,
    output hbus_pkg::hbus_word_t   rd_data_o,
    output hbus_pkg::credit_t      credits_o,
    output logic                   word_seen_o
);

    logic                 word_hit;
    logic                 valid_q;
    hbus_pkg::hbus_word_t data_q;
    hbus_pkg::credit_t    credits_q;

    assign word_hit = enable_i && rwds_rise_i && !rwds_fall_i;

    always_ff @(posedge clk) begin
        if (word_hit) begin
            data_q <= {rx_rise_i, rx_fall_i};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q   <= 1'b0;
            credits_q <= hbus_pkg::credit_t'(hbus_pkg::RD_CREDITS);
        end else begin
            if (word_hit) begin
                valid_q <= 1'b1;
            end else begin
                valid_q <= 1'b0;
            end
            // Returned credits in, delivered words out
            credits_q <= credits_q + hbus_pkg::credit_t'(rd_credit_i)
                                   - hbus_pkg::credit_t'(valid_q);
        end
    end

    assign rd_valid_o  = valid_q;
    assign rd_data_o   = data_q;
    assign credits_o   = credits_q;
    assign word_seen_o = word_hit;

endmodule

// ==== source/hbus_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// One burst at a time; credits are checked before acceptance
// st_error is left only through rst
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hbus_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_i,
    input  logic                   we_i,
    input  hbus_pkg::burst_len_t   len_i,
    input  logic                   lat_done_i,
    input  logic                   to_expired_i,
    input  hbus_pkg::credit_t      wf_count_i,
    input  hbus_pkg::credit_t      rd_credits_i,
    input  logic                   word_seen_i,
    output logic                   ready_o,
    output logic                   busy_o,
    output logic                   error_o,
    output logic                   hbus_rst_n_o,
    output logic                   hbus_cs_n_o,
    output logic                   ca_load_o,
    output logic                   ca_shift_o,
    output logic                   lat_start_o,
    output logic                   lat_run_o,
    output logic                   to_run_o,
    output logic                   ck_en_o,
    output logic                   dq_oe_o,
    output logic                   rwds_oe_o,
    output logic                   tx_sel_o,
    output logic                   wf_pop_o,
    output logic                   rc_enable_o
);

    hbus_pkg::hbus_state_e state_q;
    hbus_pkg::hbus_state_e state_d;
    logic [2:0]            step_q;
    hbus_pkg::burst_len_t  words_q;
    logic                  we_q;
    logic                  accept;
    logic                  reset_end;
    logic                  cmd_last;
    logic                  len_ok;

    // A read cannot pause, so all of its credits must be in hand
    assign len_ok  = (len_i != '0) && (we_i ? (wf_count_i >= len_i)
                                            : (rd_credits_i >= len_i));
    assign ready_o = (state_q == hbus_pkg::st_idle) && len_ok;
    assign accept  = req_i && ready_o;

    assign reset_end = (step_q == 3'(hbus_pkg::RESET_CYCLES - 1));
    assign cmd_last  = (step_q == 3'(hbus_pkg::CA_WORDS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            hbus_pkg::st_reset:   if (reset_end) state_d = hbus_pkg::st_idle;
            hbus_pkg::st_idle:    if (accept) state_d = hbus_pkg::st_command;
            hbus_pkg::st_command: if (cmd_last) state_d = hbus_pkg::st_latency;
            hbus_pkg::st_latency: begin
                if (lat_done_i) begin
                    state_d = we_q ? hbus_pkg::st_write : hbus_pkg::st_read;
                end
            end
            hbus_pkg::st_write:   if (words_q == 5'd1) state_d = hbus_pkg::st_done;
            hbus_pkg::st_read: begin
                if (word_seen_i) begin
                    if (words_q == 5'd1) state_d = hbus_pkg::st_done;
                end else if (to_expired_i) begin
                    state_d = hbus_pkg::st_error;
                end
            end
            hbus_pkg::st_done:    state_d = hbus_pkg::st_idle;
            default:              state_d = hbus_pkg::st_error;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= hbus_pkg::st_reset;
            step_q  <= '0;
            words_q <= '0;
            we_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            // Shared by the reset wait and the CA words
            if (state_d != state_q) begin
                step_q <= '0;
            end else begin
                step_q <= step_q + 1'b1;
            end
            if (accept) begin
                words_q <= len_i;
                we_q    <= we_i;
            end else if (wf_pop_o || (rc_enable_o && word_seen_i)) begin
                words_q <= words_q - 1'b1;
            end
        end
    end

    assign busy_o       = (state_q != hbus_pkg::st_idle);
    assign error_o      = (state_q == hbus_pkg::st_error);
    assign hbus_rst_n_o = (state_q != hbus_pkg::st_reset);
    assign hbus_cs_n_o  = !(state_q inside {hbus_pkg::st_command, hbus_pkg::st_latency,
                                            hbus_pkg::st_write, hbus_pkg::st_read});

    assign ca_load_o   = accept;
    assign ca_shift_o  = (state_q == hbus_pkg::st_command) && !cmd_last;
    assign lat_start_o = (state_q == hbus_pkg::st_command) && cmd_last;
    assign lat_run_o   = (state_q == hbus_pkg::st_latency);
    assign to_run_o    = (state_q == hbus_pkg::st_read);
    assign rc_enable_o = (state_q == hbus_pkg::st_read);

    // Enable is registered on the falling edge, so look one state ahead
    assign ck_en_o = state_d inside {hbus_pkg::st_command, hbus_pkg::st_latency,
                                     hbus_pkg::st_write, hbus_pkg::st_read};

    assign dq_oe_o   = (state_q == hbus_pkg::st_command) || (state_q == hbus_pkg::st_write);
    assign rwds_oe_o = (state_q == hbus_pkg::st_write);
    assign tx_sel_o  = (state_q == hbus_pkg::st_write);
    assign wf_pop_o  = (state_q == hbus_pkg::st_write);

endmodule

// ==== source/hbus_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Single clock domain; hbus_ck is a gated copy of clk
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hbus_top (
    input  logic                   clk,
    input  logic                   rst,
    // User request
    input  logic                   req_i,
    input  logic                   we_i,
    input  hbus_pkg::hbus_addr_t   addr_i,
    input  hbus_pkg::burst_len_t   len_i,
    output logic                   ready_o,
    // Write data
    input  logic                   wr_valid_i,
    input  hbus_pkg::hbus_word_t   wr_data_i,
    output logic                   wr_credit_o,
    // Read data
    output logic                   rd_valid_o,
    output hbus_pkg::hbus_word_t   rd_data_o,
    input  logic                   rd_credit_i,
    // Status
    output logic                   busy_o,
    output logic                   error_o,
    // HyperBus pins
    output logic                   hbus_ck_o,
    output logic                   hbus_cs_n_o,
    output logic                   hbus_rst_n_o,
    inout  hbus_pkg::hbus_byte_t   hbus_dq_io,
    inout  wire                    hbus_rwds_io
);

    logic ca_load, ca_shift, lat_start, lat_run, to_run;
    logic ck_en, dq_oe, rwds_oe, tx_sel, wf_pop, rc_enable;
    logic lat_done, to_expired, word_seen;
    logic rwds_rise, rwds_fall;
    hbus_pkg::credit_t    wf_count;
    hbus_pkg::credit_t    rd_credits;
    hbus_pkg::hbus_word_t ca_word;
    hbus_pkg::hbus_word_t wf_head;
    hbus_pkg::hbus_word_t tx_word;
    hbus_pkg::hbus_byte_t rx_rise;
    hbus_pkg::hbus_byte_t rx_fall;

    assign tx_word = tx_sel ? wf_head : ca_word;

    hbus_ctrl u_ctrl (
        .clk, .rst, .req_i, .we_i, .len_i,
        .lat_done_i(lat_done), .to_expired_i(to_expired), .wf_count_i(wf_count),
        .rd_credits_i(rd_credits), .word_seen_i(word_seen),
        .ready_o, .busy_o, .error_o, .hbus_rst_n_o, .hbus_cs_n_o,
        .ca_load_o(ca_load), .ca_shift_o(ca_shift), .lat_start_o(lat_start),
        .lat_run_o(lat_run), .to_run_o(to_run), .ck_en_o(ck_en), .dq_oe_o(dq_oe),
        .rwds_oe_o(rwds_oe), .tx_sel_o(tx_sel), .wf_pop_o(wf_pop),
        .rc_enable_o(rc_enable)
    );

    hbus_ca_builder u_ca (
        .clk, .rst, .load_i(ca_load), .shift_i(ca_shift), .we_i, .addr_i,
        .ca_word_o(ca_word)
    );

    hbus_latency_counter u_lat (
        .clk, .rst, .start_i(lat_start), .rwds_sample_i(rwds_rise), .run_i(lat_run),
        .to_run_i(to_run), .word_seen_i(word_seen),
        .lat_done_o(lat_done), .to_expired_o(to_expired)
    );

    hbus_ddr_io u_io (
        .clk, .rst, .ck_en_i(ck_en), .dq_oe_i(dq_oe), .rwds_oe_i(rwds_oe),
        .tx_word_i(tx_word), .rx_rise_o(rx_rise), .rx_fall_o(rx_fall),
        .rwds_rise_o(rwds_rise), .rwds_fall_o(rwds_fall), .hbus_ck_o,
        .hbus_dq_io, .hbus_rwds_io
    );

    hbus_write_fifo u_wf (
        .clk, .rst, .wr_valid_i, .wr_data_i, .pop_i(wf_pop),
        .head_o(wf_head), .count_o(wf_count), .wr_credit_o
    );

    hbus_read_capture u_rc (
        .clk, .rst, .enable_i(rc_enable), .rx_rise_i(rx_rise), .rx_fall_i(rx_fall),
        .rwds_rise_i(rwds_rise), .rwds_fall_i(rwds_fall), .rd_credit_i,
        .rd_valid_o, .rd_data_o, .credits_o(rd_credits), .word_seen_o(word_seen)
    );

endmodule

// ==== tb/hyperram_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Behavioral HyperRAM, linear memory bursts only; 2x latency chosen by lat2x_i
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hyperram_model (
    input  logic                   hbus_ck_i,
    input  logic                   hbus_cs_n_i,
    input  logic                   mute_i,
    input  logic                   lat2x_i,
    inout  hbus_pkg::hbus_byte_t   hbus_dq_io,
    inout  wire                    hbus_rwds_io,
    output int                     cmd_count_o,
    output logic                   cmd_we_o,
    output hbus_pkg::hbus_addr_t   cmd_addr_o
);

    hbus_pkg::hbus_word_t mem [hbus_pkg::hbus_addr_t];
    hbus_pkg::hbus_byte_t dq_drv;
    logic                 dq_en;
    logic                 rwds_drv;
    logic                 rwds_en;

    assign hbus_dq_io   = dq_en ? dq_drv : 'z;
    assign hbus_rwds_io = rwds_en ? rwds_drv : 1'bz;

    // Unwritten locations hold a pattern of the whole address
    function automatic hbus_pkg::hbus_word_t read_word(hbus_pkg::hbus_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[15:0] ^ a[31:16] ^ 16'h5a3c;
    endfunction

    task automatic serve_burst();
        hbus_pkg::hbus_ca_t   ca;
        hbus_pkg::hbus_byte_t hi;
        hbus_pkg::hbus_word_t w;
        hbus_pkg::hbus_addr_t a;
        logic                 lat2x;
        ca       = '0;
        lat2x    = lat2x_i && !mute_i;
        rwds_drv = lat2x;
        rwds_en  = !mute_i;
        // First CA word is already on the bus when cs falls
        for (int i = 0; i < hbus_pkg::CA_WORDS; i++) begin
            if (i > 0) begin
                @(posedge hbus_ck_i);
            end
            #2;
            hi = hbus_dq_io;
            @(negedge hbus_ck_i);
            #2;
            ca = {ca[31:0], hi, hbus_dq_io};
        end
        rwds_en    = 1'b0;
        cmd_we_o   = !ca[47];
        cmd_addr_o = {ca[44:16], ca[2:0]};
        cmd_count_o++;
        a = cmd_addr_o;
        repeat (lat2x ? 2 * hbus_pkg::TACC_CLOCKS : hbus_pkg::TACC_CLOCKS) begin
            @(posedge hbus_ck_i);
        end
        // Data phase runs until cs rises
        forever begin
            @(posedge hbus_ck_i or posedge hbus_cs_n_i);
            if (hbus_cs_n_i) begin
                break;
            end
            if (cmd_we_o) begin
                #2;
                hi = hbus_dq_io;
                @(negedge hbus_ck_i);
                #2;
                mem[a] = {hi, hbus_dq_io};
            end else if (!mute_i) begin
                w = read_word(a);
                #1;
                dq_en    = 1'b1;
                rwds_en  = 1'b1;
                dq_drv   = w[15:8];
                rwds_drv = 1'b1;
                @(negedge hbus_ck_i);
                #1;
                dq_drv   = w[7:0];
                rwds_drv = 1'b0;
            end
            a = a + 1;
        end
        dq_en   = 1'b0;
        rwds_en = 1'b0;
    endtask

    initial begin
        dq_en       = 1'b0;
        dq_drv      = '0;
        rwds_en     = 1'b0;
        rwds_drv    = 1'b0;
        cmd_count_o = 0;
        cmd_we_o    = 1'b0;
        cmd_addr_o  = '0;
        forever begin
            @(negedge hbus_cs_n_i);
            serve_burst();
        end
    end

endmodule

// ==== tb/tb_hbus.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Random bursts against a reference memory; stops at the first mismatch
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_hbus;

    logic clk, rst, req, we, wr_valid, rd_credit, mute, lat2x, hold_credits;
    hbus_pkg::hbus_addr_t addr;
    hbus_pkg::burst_len_t len;
    hbus_pkg::hbus_word_t wr_data, rd_data;
    logic ready, wr_credit, rd_valid, busy, error, hbus_ck, hbus_cs_n, hbus_rst_n;
    wire hbus_pkg::hbus_byte_t hbus_dq;
    wire                       hbus_rwds;
    int                        cmd_count;
    logic                      cmd_we;
    hbus_pkg::hbus_addr_t      cmd_addr;

    hbus_pkg::hbus_word_t ref_mem [hbus_pkg::hbus_addr_t];
    hbus_pkg::hbus_word_t rx_q [$];
    int   dut_rd_credits, owed_credits, wr_credits, accepted, cs_falls;
    logic cs_n_prev;

    // Board pull-down on RWDS
    pulldown (hbus_rwds);

    hbus_top dut (
        .clk(clk), .rst(rst), .req_i(req), .we_i(we), .addr_i(addr), .len_i(len),
        .ready_o(ready), .wr_valid_i(wr_valid), .wr_data_i(wr_data),
        .wr_credit_o(wr_credit), .rd_valid_o(rd_valid), .rd_data_o(rd_data),
        .rd_credit_i(rd_credit), .busy_o(busy), .error_o(error), .hbus_ck_o(hbus_ck),
        .hbus_cs_n_o(hbus_cs_n), .hbus_rst_n_o(hbus_rst_n), .hbus_dq_io(hbus_dq),
        .hbus_rwds_io(hbus_rwds)
    );

    hyperram_model u_ram (
        .hbus_ck_i(hbus_ck), .hbus_cs_n_i(hbus_cs_n), .mute_i(mute), .lat2x_i(lat2x),
        .hbus_dq_io(hbus_dq), .hbus_rwds_io(hbus_rwds), .cmd_count_o(cmd_count),
        .cmd_we_o(cmd_we), .cmd_addr_o(cmd_addr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_error(string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_timeout(string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_word(hbus_pkg::hbus_word_t got, hbus_pkg::hbus_word_t exp, string msg);
        if (got !== exp) begin
            report_error($sformatf("%s: got %h, expected %h", msg, got, exp));
        end
    endtask

    task automatic check_addr(hbus_pkg::hbus_addr_t got, hbus_pkg::hbus_addr_t exp, string msg);
        if (got !== exp) begin
            report_error($sformatf("%s: got %h, expected %h", msg, got, exp));
        end
    endtask

    task automatic check_bit(logic got, logic exp, string msg);
        if (got !== exp) begin
            report_error($sformatf("%s: got %b, expected %b", msg, got, exp));
        end
    endtask

    function automatic hbus_pkg::hbus_word_t expected_word(hbus_pkg::hbus_addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a[15:0] ^ a[31:16] ^ 16'h5a3c;
    endfunction

    // Bus observer checking credits, framing and status
    always @(negedge clk) begin
        if (rst) begin
            dut_rd_credits = hbus_pkg::RD_CREDITS;
            owed_credits   = 0;
            accepted       = 0;
            cs_falls       = 0;
            rx_q.delete();
        end else begin
            if (ready) begin
                check_bit(hbus_rst_n, 1'b1, "ready_o high with device in reset");
            end
            if (ready && !we) begin
                check_bit(len <= dut_rd_credits, 1'b1, "read offered beyond read credits");
            end
            if (!busy) begin
                check_bit(hbus_cs_n, 1'b1, "cs low while not busy");
            end
            if (req && ready) begin
                accepted++;
            end
            if (cs_n_prev && !hbus_cs_n) begin
                cs_falls++;
                check_bit(cs_falls == accepted, 1'b1, "cs span without one accepted request");
            end
            if (rd_valid) begin
                check_bit(dut_rd_credits > 0, 1'b1, "read word without a read credit");
                rx_q.push_back(rd_data);
                owed_credits++;
            end
            if (wr_credit) begin
                wr_credits++;
                check_bit(wr_credits <= hbus_pkg::WR_CREDITS, 1'b1, "write credit overflow");
            end
            dut_rd_credits = dut_rd_credits + int'(rd_credit) - int'(rd_valid);
        end
        cs_n_prev = hbus_cs_n;
    end

    // Returns consumed read credits at random, unless held back
    initial begin
        rd_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rd_credit = 1'b0;
            if (!rst && !hold_credits && owed_credits > 0 && $urandom_range(2) == 0) begin
                rd_credit = 1'b1;
                owed_credits--;
            end
        end
    end

    task automatic apply_reset();
        int t;
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_bit(hbus_rst_n, 1'b0, "device reset during rst");
            check_bit(hbus_cs_n, 1'b1, "cs during rst");
            check_bit(busy, 1'b1, "busy during rst");
            check_bit(error, 1'b0, "error during rst");
            check_bit(ready, 1'b0, "ready during rst");
        end
        @(posedge clk);
        #1;
        rst        = 1'b0;
        wr_credits = hbus_pkg::WR_CREDITS;
        t = 0;
        do begin
            @(negedge clk);
            if (!hbus_rst_n) begin
                t++;
                check_bit(busy, 1'b1, "busy during device reset");
            end
        end while (!hbus_rst_n && t < 20);
        if (!hbus_rst_n) begin
            report_timeout("device reset release");
        end
        check_bit(t == hbus_pkg::RESET_CYCLES, 1'b1, "device reset length");
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (busy && t < 300);
        if (busy) begin
            report_timeout("busy_o to fall");
        end
    endtask

    task automatic send_request(logic we_v, hbus_pkg::hbus_addr_t a, int n);
        int t;
        @(posedge clk);
        #1;
        lat2x = $urandom_range(1);
        req   = 1'b1;
        we    = we_v;
        addr  = a;
        len   = hbus_pkg::burst_len_t'(n);
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!ready && t < 500);
        if (!ready) begin
            report_timeout("request acceptance");
        end
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    task automatic wait_command(int n_before, logic we_v, hbus_pkg::hbus_addr_t a);
        int t;
        t = 0;
        while (cmd_count == n_before && t < 100) begin
            @(negedge clk);
            t++;
        end
        if (cmd_count == n_before) begin
            report_timeout("the device to decode a command");
        end
        check_bit(cmd_we, we_v, "decoded write flag");
        check_addr(cmd_addr, a, "decoded address");
    endtask

    task automatic do_write(hbus_pkg::hbus_addr_t a, int n);
        int                   t;
        int                   n_cmd;
        hbus_pkg::hbus_word_t w;
        t = 0;
        while (wr_credits < n && t < 100) begin
            @(negedge clk);
            t++;
        end
        if (wr_credits < n) begin
            report_timeout("write credits");
        end
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            #1;
            w        = hbus_pkg::hbus_word_t'($urandom);
            wr_valid = 1'b1;
            wr_data  = w;
            wr_credits--;
            ref_mem[a + k] = w;
        end
        @(posedge clk);
        #1;
        wr_valid = 1'b0;
        n_cmd = cmd_count;
        send_request(1'b1, a, n);
        wait_command(n_cmd, 1'b1, a);
        wait_idle();
    endtask

    task automatic do_read(hbus_pkg::hbus_addr_t a, int n);
        int t;
        int n_cmd;
        rx_q.delete();
        n_cmd = cmd_count;
        send_request(1'b0, a, n);
        wait_command(n_cmd, 1'b0, a);
        t = 0;
        while (rx_q.size() < n && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (rx_q.size() < n) begin
            report_timeout("read data");
        end
        for (int k = 0; k < n; k++) begin
            check_word(rx_q[k], expected_word(a + k), $sformatf("read word %0d", k));
        end
        wait_idle();
        check_bit(rx_q.size() == n, 1'b1, "number of read words");
    endtask

    function automatic hbus_pkg::hbus_addr_t window_addr();
        return 32'h0012_3450 + $urandom_range(63);
    endfunction

    initial begin
        int                   n;
        int                   t;
        hbus_pkg::hbus_addr_t a;
        void'($urandom(21491));
        rst          = 1'b1;
        req          = 1'b0;
        we           = 1'b0;
        addr         = '0;
        len          = '0;
        wr_valid     = 1'b0;
        wr_data      = '0;
        mute         = 1'b0;
        lat2x        = 1'b0;
        hold_credits = 1'b0;
        apply_reset();

        do_write(32'h0000_0010, 4);
        do_read(32'h0000_0010, 4);

        repeat (40) begin
            n = $urandom_range(16, 1);
            if ($urandom_range(1) == 1) begin
                a = ($urandom_range(3) == 0) ? hbus_pkg::hbus_addr_t'($urandom) : window_addr();
                do_write(a, n);
            end else begin
                do_read(window_addr(), n);
            end
        end

        // Write credit pool must be whole again
        t = 0;
        while (wr_credits != hbus_pkg::WR_CREDITS && t < 50) begin
            @(negedge clk);
            t++;
        end
        check_bit(wr_credits == hbus_pkg::WR_CREDITS, 1'b1, "write credit pool after writes");

        // Held credits block a full-length read
        t = 0;
        while (owed_credits != 0 && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (owed_credits != 0) begin
            report_timeout("read credits to return");
        end
        hold_credits = 1'b1;
        do_read(window_addr(), 12);
        @(posedge clk);
        #1;
        req  = 1'b1;
        we   = 1'b0;
        len  = 5'd16;
        repeat (20) begin
            @(negedge clk);
            check_bit(ready, 1'b0, "ready for read beyond credits");
        end
        @(posedge clk);
        #1;
        req          = 1'b0;
        hold_credits = 1'b0;
        do_read(window_addr(), 16);

        // Muted device ends in the sticky error state
        mute = 1'b1;
        send_request(1'b0, window_addr(), 4);
        t = 0;
        while (!error && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (!error) begin
            report_timeout("error_o after a silent read");
        end
        @(posedge clk);
        #1;
        req = 1'b1;
        we  = 1'b0;
        len = 5'd1;
        repeat (20) begin
            @(posedge clk);
            #2;
            check_bit(hbus_ck, 1'b0, "bus clock in error state");
            @(negedge clk);
            check_bit(error, 1'b1, "error_o sticky");
            check_bit(hbus_cs_n, 1'b1, "cs in error state");
            check_bit(ready, 1'b0, "ready in error state");
            check_bit(busy, 1'b1, "busy in error state");
        end
        @(posedge clk);
        #1;
        req  = 1'b0;
        mute = 1'b0;
        apply_reset();
        @(negedge clk);
        check_bit(error, 1'b0, "error_o after reset");
        wait_idle();

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== filelist.f ====
source/hbus_pkg.sv
source/hbus_ca_builder.sv
source/hbus_latency_counter.sv
source/hbus_ddr_io.sv
source/hbus_write_fifo.sv
source/hbus_read_capture.sv
source/hbus_ctrl.sv
source/hbus_top.sv
tb/hyperram_model.sv
tb/tb_hbus.sv
